// File: Bender.yml
package:
  name: decodeExecute

sources:
  - mipsPkg.sv
  - controlDecoder.sv
  - registerFile.sv
  - idExRegister.sv
  - executeUnit.sv
  - decodeExecute.sv
  - target: test
    files:
      - decodeExecuteTb.sv

// File: all.f
mipsPkg.sv
controlDecoder.sv
registerFile.sv
idExRegister.sv
executeUnit.sv
decodeExecute.sv
decodeExecuteTb.sv

// File: controlDecoder.sv
`timescale 1ns/1ns

module controlDecoder (
    input  mipsPkg::instrWord                     instruction,
    output logic                                  regWrite,
    output logic                                  aluSrc,
    output logic                                  memWrite,
    output logic                                  memRead,
    output logic                                  branch,
    output logic                                  branchNe,
    output logic [1:0]                            memToReg,
    output logic [1:0]                            byteSel,
    output logic [1:0]                            regDst,
    output logic [mipsPkg::aluOpWidth-1:0]        aluOp,
    output logic [mipsPkg::dataWidth-1:0]         immExt
);
    import mipsPkg::*;

    logic [dataWidth-1:0] signExt;
    logic [dataWidth-1:0] zeroExt;

    assign signExt = {{(dataWidth-immWidth){instruction.iType.imm[immWidth-1]}},
                      instruction.iType.imm};
    assign zeroExt = {{(dataWidth-immWidth){1'b0}}, instruction.iType.imm};

    always_comb begin
        // Bubble unless an opcode below matches
        regWrite = 1'b0;
        aluSrc   = 1'b0;
        memWrite = 1'b0;
        memRead  = 1'b0;
        branch   = 1'b0;
        branchNe = 1'b0;
        memToReg = 2'b00;
        byteSel  = 2'b00;
        regDst   = 2'b00;
        aluOp    = aluAdd;
        immExt   = '0;
        case (instruction.iType.opcode)
            opRType: begin
                regWrite = 1'b1;
                memToReg = memToRegAlu;
                regDst   = regDstRd;
                immExt   = signExt;
                case (instruction.rType.funct)
                    fnAdd: aluOp = aluAdd;
                    fnSub: aluOp = aluSub;
                    fnAnd: aluOp = aluAnd;
                    fnOr:  aluOp = aluOr;
                    fnXor: aluOp = aluXor;
                    fnNor: aluOp = aluNor;
                    fnSlt: aluOp = aluSlt;
                    fnSll, fnSrl: begin
                        aluOp  = (instruction.rType.funct == fnSll) ? aluSll : aluSrl;
                        // Shift amount rides in the immediate path
                        immExt = {{(dataWidth-regAddrWidth){1'b0}}, instruction.rType.shamt};
                    end
                    default: begin
                        regWrite = 1'b0;
                        memToReg = 2'b00;
                        regDst   = 2'b00;
                        immExt   = '0;
                    end
                endcase
            end
            opAddi, opSlti, opAndi, opOri, opLui: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                memToReg = memToRegAlu;
                regDst   = regDstRt;
                immExt   = signExt;
                case (instruction.iType.opcode)
                    opSlti:  aluOp = aluSlt;
                    opAndi:  aluOp = aluAnd;
                    opOri:   aluOp = aluOr;
                    opLui:   aluOp = aluLui;
                    default: aluOp = aluAdd;
                endcase
                if (instruction.iType.opcode inside {opAndi, opOri}) begin
                    immExt = zeroExt;
                end
            end
            opLw, opLb: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                memRead  = 1'b1;
                memToReg = memToRegMem;
                regDst   = regDstRt;
                byteSel  = (instruction.iType.opcode == opLb) ? byteSelByte : byteSelWord;
                immExt   = signExt;
            end
            opSw, opSb: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
                byteSel  = (instruction.iType.opcode == opSb) ? byteSelByte : byteSelWord;
                immExt   = signExt;
            end
            opBeq, opBne: begin
                branch   = 1'b1;
                branchNe = (instruction.iType.opcode == opBne);
                aluOp    = aluSub;
                immExt   = signExt;
            end
            default: ;
        endcase
    end

endmodule

// File: decodeExecute.sv
`timescale 1ns/1ns

module decodeExecute (
    input  logic                                  Clock,
    input  logic                                  arstN,
    input  mipsPkg::instrWord                     instruction,
    input  logic [mipsPkg::dataWidth-1:0]         pc,
    input  logic                                  flush,
    input  logic                                  stall,
    input  logic                                  wbWrite,
    input  logic [mipsPkg::regAddrWidth-1:0]      wbAddr,
    input  logic [mipsPkg::dataWidth-1:0]         wbData,
    output logic [mipsPkg::dataWidth-1:0]         aluResult,
    output logic [mipsPkg::dataWidth-1:0]         storeData,
    output logic [mipsPkg::dataWidth-1:0]         branchTarget,
    output logic [mipsPkg::regAddrWidth-1:0]      destReg,
    output logic [1:0]                            memToReg,
    output logic [1:0]                            byteSel,
    output logic                                  branchTaken,
    output logic                                  regWrite,
    output logic                                  memWrite,
    output logic                                  memRead
);
    import mipsPkg::*;

    // Decode side
    logic                  dRegWrite, dAluSrc, dMemWrite, dMemRead, dBranch, dBranchNe;
    logic [1:0]            dMemToReg, dByteSel, dRegDst;
    logic [aluOpWidth-1:0] dAluOp;
    logic [dataWidth-1:0]  dImm, dRead1, dRead2;

    // Execute side
    logic                  eAluSrc, eBranch, eBranchNe;
    logic [1:0]            eRegDst;
    logic [aluOpWidth-1:0] eAluOp;
    logic [dataWidth-1:0]  ePc, eImm, eRead1, eRead2;
    instrWord              eInstruction;

    controlDecoder decoder (
        .instruction(instruction), .regWrite(dRegWrite), .aluSrc(dAluSrc),
        .memWrite(dMemWrite), .memRead(dMemRead), .branch(dBranch), .branchNe(dBranchNe),
        .memToReg(dMemToReg), .byteSel(dByteSel), .regDst(dRegDst), .aluOp(dAluOp),
        .immExt(dImm)
    );

    registerFile regFile (
        .Clock(Clock), .arstN(arstN), .writeEnable(wbWrite),
        .readAddr1(instruction.rType.rs), .readAddr2(instruction.rType.rt),
        .writeAddr(wbAddr), .writeData(wbData), .readData1(dRead1), .readData2(dRead2)
    );

    idExRegister stageReg (
        .Clock(Clock), .arstN(arstN), .flush(flush), .stall(stall),
        .regWriteIn(dRegWrite), .aluSrcIn(dAluSrc), .memWriteIn(dMemWrite),
        .memReadIn(dMemRead), .branchIn(dBranch), .branchNeIn(dBranchNe),
        .memToRegIn(dMemToReg), .byteSelIn(dByteSel), .regDstIn(dRegDst),
        .aluOpIn(dAluOp), .pcIn(pc), .instructionIn(instruction), .immIn(dImm),
        .readData1In(dRead1), .readData2In(dRead2),
        .regWriteOut(regWrite), .aluSrcOut(eAluSrc), .memWriteOut(memWrite),
        .memReadOut(memRead), .branchOut(eBranch), .branchNeOut(eBranchNe),
        .memToRegOut(memToReg), .byteSelOut(byteSel), .regDstOut(eRegDst),
        .aluOpOut(eAluOp), .pcOut(ePc), .instructionOut(eInstruction), .immOut(eImm),
        .readData1Out(eRead1), .readData2Out(eRead2)
    );

    executeUnit execute (
        .instruction(eInstruction), .pc(ePc), .readData1(eRead1), .readData2(eRead2),
        .immExt(eImm), .aluSrc(eAluSrc), .regDst(eRegDst), .branch(eBranch),
        .branchNe(eBranchNe), .aluOp(eAluOp), .aluResult(aluResult),
        .branchTarget(branchTarget), .storeData(storeData), .destReg(destReg),
        .branchTaken(branchTaken)
    );

endmodule

// File: decodeExecuteTb.sv
`timescale 1ns/1ns

module decodeExecuteTb;
    import mipsPkg::*;

    localparam int clockPeriod = 40;
    localparam int randomCount = 300;
    // Reset, register fill, directed block, random block and drain
    localparam int stimCycles  = 4 + 32 + 47 + randomCount + 3;

    logic                    Clock;
    logic                    arstN;
    instrWord                instruction;
    logic [dataWidth-1:0]    pc;
    logic                    flush;
    logic                    stall;
    logic                    wbWrite;
    logic [regAddrWidth-1:0] wbAddr;
    logic [dataWidth-1:0]    wbData;
    logic [dataWidth-1:0]    aluResult, storeData, branchTarget;
    logic [regAddrWidth-1:0] destReg;
    logic [1:0]              memToReg, byteSel;
    logic                    branchTaken, regWrite, memWrite, memRead;

    // Reference state
    logic [dataWidth-1:0]    modelRegs [regCount];
    logic [dataWidth-1:0]    expAlu, expStore, expTarget;
    logic [regAddrWidth-1:0] expDest;
    logic [1:0]              expMemToReg, expByteSel;
    logic                    expTaken, expRegWrite, expMemWrite, expMemRead;

    logic [functWidth-1:0]  functChoices [9] = '{fnAdd, fnSub, fnAnd, fnOr, fnXor, fnNor,
                                                 fnSlt, fnSll, fnSrl};
    logic [opcodeWidth-1:0] opChoices [11] = '{opAddi, opAndi, opOri, opSlti, opLui, opLw,
                                               opSw, opLb, opSb, opBeq, opBne};

    decodeExecute uut (.*);

    initial begin
        Clock = 1'b0;
        forever #(clockPeriod / 2) Clock = ~Clock;
    end

    initial begin : watchdog
        #((stimCycles + 50) * clockPeriod);
        $display("Timeout: stimulus did not complete within %0d cycles", stimCycles + 50);
        stopWithFailure();
    end

    ////////////////////
    // Failure reporting
    task automatic stopWithFailure();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("mismatch %s expected %h actual %h", name, expected, actual);
        stopWithFailure();
    endtask

    // Register read as seen by decode, pending writeback first
    function automatic logic [dataWidth-1:0] readModel(input logic [regAddrWidth-1:0] addr);
        if (addr == '0) return '0;
        if (wbWrite && wbAddr == addr) return wbData;
        return modelRegs[addr];
    endfunction

    ////////////////////
    // Expected execute results of one instruction
    task automatic predict(input instrWord ins, input logic [31:0] pcV, input logic [31:0] a,
                           input logic [31:0] b, output logic [31:0] alu,
                           output logic [31:0] target, output logic [4:0] dest,
                           output logic [1:0] mtr, output logic [1:0] bsel,
                           output logic taken, output logic rw, output logic mw,
                           output logic mr);
        logic [31:0] ext;
        ext    = {{16{ins.iType.imm[15]}}, ins.iType.imm};
        alu    = a + b;
        dest   = ins.iType.rt;
        {mtr, bsel, taken, rw, mw, mr} = '0;
        case (ins.iType.opcode)
            opRType: begin
                {rw, mtr, dest} = {1'b1, memToRegAlu, ins.rType.rd};
                case (ins.rType.funct)
                    fnAdd: alu = a + b;
                    fnSub: alu = a - b;
                    fnAnd: alu = a & b;
                    fnOr:  alu = a | b;
                    fnXor: alu = a ^ b;
                    fnNor: alu = ~(a | b);
                    fnSlt: alu = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    fnSll: {alu, ext} = {b << ins.rType.shamt, 27'd0, ins.rType.shamt};
                    fnSrl: {alu, ext} = {b >> ins.rType.shamt, 27'd0, ins.rType.shamt};
                    // Undefined funct is a bubble
                    default: {rw, mtr, dest, ext} = {1'b0, 2'b00, ins.iType.rt, 32'd0};
                endcase
            end
            opAddi, opSlti, opAndi, opOri, opLui: begin
                {rw, mtr} = {1'b1, memToRegAlu};
                if (ins.iType.opcode == opAndi || ins.iType.opcode == opOri)
                    ext = {16'h0000, ins.iType.imm};
                case (ins.iType.opcode)
                    opAddi:  alu = a + ext;
                    opSlti:  alu = ($signed(a) < $signed(ext)) ? 32'd1 : 32'd0;
                    opAndi:  alu = a & ext;
                    opOri:   alu = a | ext;
                    default: alu = {ins.iType.imm, 16'h0000};
                endcase
            end
            opLw, opLb: begin
                {alu, mr, rw, mtr} = {a + ext, 1'b1, 1'b1, memToRegMem};
                bsel = (ins.iType.opcode == opLb) ? byteSelByte : byteSelWord;
            end
            opSw, opSb: begin
                {alu, mw} = {a + ext, 1'b1};
                bsel = (ins.iType.opcode == opSb) ? byteSelByte : byteSelWord;
            end
            opBeq: {alu, taken} = {a - b, a == b};
            opBne: {alu, taken} = {a - b, a != b};
            default: ext = '0;
        endcase
        target = pcV + 32'd4 + ext * 4;
    endtask

    always @(posedge Clock or negedge arstN) begin : referenceModel
        logic [dataWidth-1:0]    alu;
        logic [dataWidth-1:0]    target;
        logic [regAddrWidth-1:0] dest;
        logic [1:0]              mtr;
        logic [1:0]              bsel;
        logic                    taken, rw, mw, mr;
        if (!arstN) begin
            for (int i = 0; i < regCount; i++) modelRegs[i] <= '0;
        end else if (wbWrite && wbAddr != '0) begin
            modelRegs[wbAddr] <= wbData;
        end
        if (!arstN || flush) begin
            // Zero pc still gives a target of 4
            {expAlu, expStore, expTarget, expDest} <= {64'd0, 32'd4, 5'd0};
            {expMemToReg, expByteSel, expTaken, expRegWrite, expMemWrite, expMemRead} <= '0;
        end else if (!stall) begin
            predict(instruction, pc, readModel(instruction.rType.rs),
                    readModel(instruction.rType.rt), alu, target, dest, mtr, bsel,
                    taken, rw, mw, mr);
            {expAlu, expStore, expTarget, expDest} <=
                {alu, readModel(instruction.rType.rt), target, dest};
            {expMemToReg, expByteSel, expTaken, expRegWrite, expMemWrite, expMemRead} <=
                {mtr, bsel, taken, rw, mw, mr};
        end
    end

    ////////////////////
    // Output checks
    assert property (@(posedge Clock) disable iff (!arstN) aluResult === expAlu)
        else reportMismatch("aluResult", $sampled(expAlu), $sampled(aluResult));
    assert property (@(posedge Clock) disable iff (!arstN) storeData === expStore)
        else reportMismatch("storeData", $sampled(expStore), $sampled(storeData));
    assert property (@(posedge Clock) disable iff (!arstN) branchTarget === expTarget)
        else reportMismatch("branchTarget", $sampled(expTarget), $sampled(branchTarget));
    assert property (@(posedge Clock) disable iff (!arstN) destReg === expDest)
        else reportMismatch("destReg", $sampled(expDest), $sampled(destReg));
    assert property (@(posedge Clock) disable iff (!arstN) memToReg === expMemToReg)
        else reportMismatch("memToReg", $sampled(expMemToReg), $sampled(memToReg));
    assert property (@(posedge Clock) disable iff (!arstN) byteSel === expByteSel)
        else reportMismatch("byteSel", $sampled(expByteSel), $sampled(byteSel));
    assert property (@(posedge Clock) disable iff (!arstN) branchTaken === expTaken)
        else reportMismatch("branchTaken", $sampled(expTaken), $sampled(branchTaken));
    assert property (@(posedge Clock) disable iff (!arstN) regWrite === expRegWrite)
        else reportMismatch("regWrite", $sampled(expRegWrite), $sampled(regWrite));
    assert property (@(posedge Clock) disable iff (!arstN) memWrite === expMemWrite)
        else reportMismatch("memWrite", $sampled(expMemWrite), $sampled(memWrite));
    assert property (@(posedge Clock) disable iff (!arstN) memRead === expMemRead)
        else reportMismatch("memRead", $sampled(expMemRead), $sampled(memRead));

    ////////////////////
    // Stimulus
    function automatic instrWord rInstr(input logic [5:0] fn, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [4:0] rd,
                                        input logic [4:0] shamt);
        return {opRType, rs, rt, rd, shamt, fn};
    endfunction

    function automatic instrWord iInstr(input logic [5:0] op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic instrWord randomInstr();
        int pick;
        pick = $urandom_range(0, 20);
        if (pick < 9) return rInstr(functChoices[pick], $urandom, $urandom, $urandom, $urandom);
        // Opcode 3f is undefined and decodes as a bubble
        if (pick < 20) return iInstr(opChoices[pick - 9], $urandom, $urandom, $urandom);
        return iInstr(6'h3f, $urandom, $urandom, $urandom);
    endfunction

    task automatic driveCycle(input instrWord ins, input logic fl, input logic st,
                              input logic we, input logic [4:0] wa, input logic [31:0] wd);
        @(posedge Clock);
        instruction <= ins;
        pc          <= $urandom & 32'hffff_fffc;
        {flush, stall, wbWrite, wbAddr, wbData} <= {fl, st, we, wa, wd};
    endtask

    initial begin : stimulus
        void'($urandom(32'hd76b));
        {arstN, instruction, pc, flush, stall, wbWrite, wbAddr, wbData} = {1'b1, 104'd0};
        #(clockPeriod / 4) arstN = 1'b0;
        repeat (4) @(posedge Clock);
        arstN <= 1'b1;
        for (int r = 0; r < regCount; r++) driveCycle('0, 1'b0, 1'b0, 1'b1, r, $urandom);
        foreach (functChoices[i]) begin
            driveCycle(rInstr(functChoices[i], i + 1, i + 3, i + 5, i + 7), 0, 0, 0, 0, 0);
        end
        // Each I-type opcode with a negative and a positive immediate
        foreach (opChoices[i]) begin
            driveCycle(iInstr(opChoices[i], i + 2, i + 4, 16'h8000 | i), 0, 0, 0, 0, 0);
            driveCycle(iInstr(opChoices[i], i + 2, i + 4, 16'h0123 + i), 0, 0, 0, 0, 0);
        end
        // Branch operands equal and unequal
        driveCycle('0, 0, 0, 1, 5'd20, 32'h5a5a0001);
        driveCycle('0, 0, 0, 1, 5'd21, 32'h5a5a0001);
        driveCycle('0, 0, 0, 1, 5'd22, 32'h5a5a0002);
        driveCycle(iInstr(opBeq, 20, 21, 16'hfff0), 0, 0, 0, 0, 0);
        driveCycle(iInstr(opBeq, 20, 22, 16'h0010), 0, 0, 0, 0, 0);
        driveCycle(iInstr(opBne, 20, 21, 16'h0020), 0, 0, 0, 0, 0);
        driveCycle(iInstr(opBne, 20, 22, 16'hffe0), 0, 0, 0, 0, 0);
        // Write to register 0, then read it
        driveCycle('0, 0, 0, 1, 5'd0, 32'hdeadbeef);
        driveCycle(rInstr(fnOr, 0, 0, 8, 0), 0, 0, 0, 0, 0);
        // Writeback and read of one register in the same cycle
        driveCycle(rInstr(fnAdd, 9, 9, 10, 0), 0, 0, 1, 5'd9, 32'h0badf00d);
        // Three stall cycles, then flush together with stall
        driveCycle(rInstr(fnSub, 3, 4, 5, 0), 0, 0, 0, 0, 0);
        repeat (3) driveCycle(iInstr(opLw, 1, 2, 16'h0040), 0, 1, 0, 0, 0);
        driveCycle(iInstr(opSw, 1, 2, 16'h0040), 1, 1, 0, 0, 0);
        driveCycle(iInstr(opSw, 1, 2, 16'h0040), 1, 0, 0, 0, 0);
        for (int n = 0; n < randomCount; n++) begin
            driveCycle(randomInstr(), ($urandom % 10) == 0, ($urandom % 10) == 0,
                       ($urandom % 4) == 0, $urandom, $urandom);
        end
        repeat (2) driveCycle('0, 0, 0, 0, 0, 0);
        @(posedge Clock);
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: executeUnit.sv
`timescale 1ns/1ns

module executeUnit (
    input  mipsPkg::instrWord                     instruction,
    input  logic [mipsPkg::dataWidth-1:0]         pc,
    input  logic [mipsPkg::dataWidth-1:0]         readData1,
    input  logic [mipsPkg::dataWidth-1:0]         readData2,
    input  logic [mipsPkg::dataWidth-1:0]         immExt,
    input  logic                                  aluSrc,
    input  logic [1:0]                            regDst,
    input  logic                                  branch,
    input  logic                                  branchNe,
    input  logic [mipsPkg::aluOpWidth-1:0]        aluOp,
    output logic [mipsPkg::dataWidth-1:0]         aluResult,
    output logic [mipsPkg::dataWidth-1:0]         branchTarget,
    output logic [mipsPkg::dataWidth-1:0]         storeData,
    output logic [mipsPkg::regAddrWidth-1:0]      destReg,
    output logic                                  branchTaken
);
    import mipsPkg::*;

    logic [dataWidth-1:0] operandB;
    logic [4:0]           shiftAmount;
    logic                 operandsEqual;

    assign operandB    = aluSrc ? immExt : readData2;
    assign shiftAmount = immExt[4:0];

    ////////////////////
    // ALU
    always_comb begin
        case (aluOp)
            aluAdd:  aluResult = readData1 + operandB;
            aluSub:  aluResult = readData1 - operandB;
            aluAnd:  aluResult = readData1 & operandB;
            aluOr:   aluResult = readData1 | operandB;
            aluXor:  aluResult = readData1 ^ operandB;
            aluNor:  aluResult = ~(readData1 | operandB);
            aluSlt:  aluResult = {{(dataWidth-1){1'b0}},
                                  ($signed(readData1) < $signed(operandB))};
            aluSll:  aluResult = readData2 << shiftAmount;
            aluSrl:  aluResult = readData2 >> shiftAmount;
            aluLui:  aluResult = {immExt[15:0], 16'h0000};
            default: aluResult = '0;
        endcase
    end

    ////////////////////
    // Branch decision and target
    assign operandsEqual = (readData1 == readData2);
    assign branchTaken   = branch && (branchNe ? !operandsEqual : operandsEqual);
    assign branchTarget  = pc + 32'd4 + {immExt[dataWidth-3:0], 2'b00};

    // Store data is the rt operand as registered
    assign storeData = readData2;
    assign destReg   = (regDst == regDstRd) ? instruction.rType.rd : instruction.rType.rt;

endmodule

// File: idExRegister.sv
`timescale 1ns/1ns

module idExRegister (
    input  logic                              Clock,
    input  logic                              arstN,
    input  logic                              flush,
    input  logic                              stall,
    input  logic                              regWriteIn,
    input  logic                              aluSrcIn,
    input  logic                              memWriteIn,
    input  logic                              memReadIn,
    input  logic                              branchIn,
    input  logic                              branchNeIn,
    input  logic [1:0]                        memToRegIn,
    input  logic [1:0]                        byteSelIn,
    input  logic [1:0]                        regDstIn,
    input  logic [mipsPkg::aluOpWidth-1:0]    aluOpIn,
    input  logic [mipsPkg::dataWidth-1:0]     pcIn,
    input  mipsPkg::instrWord                 instructionIn,
    input  logic [mipsPkg::dataWidth-1:0]     immIn,
    input  logic [mipsPkg::dataWidth-1:0]     readData1In,
    input  logic [mipsPkg::dataWidth-1:0]     readData2In,
    output logic                              regWriteOut,
    output logic                              aluSrcOut,
    output logic                              memWriteOut,
    output logic                              memReadOut,
    output logic                              branchOut,
    output logic                              branchNeOut,
    output logic [1:0]                        memToRegOut,
    output logic [1:0]                        byteSelOut,
    output logic [1:0]                        regDstOut,
    output logic [mipsPkg::aluOpWidth-1:0]    aluOpOut,
    output logic [mipsPkg::dataWidth-1:0]     pcOut,
    output mipsPkg::instrWord                 instructionOut,
    output logic [mipsPkg::dataWidth-1:0]     immOut,
    output logic [mipsPkg::dataWidth-1:0]     readData1Out,
    output logic [mipsPkg::dataWidth-1:0]     readData2Out
);
    import mipsPkg::*;

    // All stage outputs as one vector
    logic [12+aluOpWidth+5*dataWidth-1:0] stageIn;
    logic [12+aluOpWidth+5*dataWidth-1:0] stageOut;

    assign stageIn = {regWriteIn, aluSrcIn, memWriteIn, memReadIn, branchIn, branchNeIn,
                      memToRegIn, byteSelIn, regDstIn, aluOpIn, pcIn, instructionIn,
                      immIn, readData1In, readData2In};

    assign {regWriteOut, aluSrcOut, memWriteOut, memReadOut, branchOut, branchNeOut,
            memToRegOut, byteSelOut, regDstOut, aluOpOut, pcOut, instructionOut,
            immOut, readData1Out, readData2Out} = stageOut;

    ////////////////////
    // Flush beats stall, stall holds
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            stageOut <= '0;
        end else if (flush) begin
            stageOut <= '0;
        end else if (!stall) begin
            stageOut <= stageIn;
        end
    end

    assert property (@(posedge Clock) disable iff (!arstN)
        flush |=> !(regWriteOut || memWriteOut || memReadOut || branchOut || branchNeOut))
        else $error("control survived a flush");
    assert property (@(posedge Clock) disable iff (!arstN)
        (stall && !flush) |=> $stable(stageOut))
        else $error("stage register moved during stall");

endmodule

// File: mipsPkg.sv
package mipsPkg;

    // Widths
    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int aluOpWidth   = 5;
    localparam int opcodeWidth  = 6;
    localparam int functWidth   = 6;
    localparam int immWidth     = 16;
    localparam int regCount     = 1 << regAddrWidth;

    ////////////////////
    // ALU operation codes, zero is add so a bubble computes 0 + 0
    localparam logic [aluOpWidth-1:0] aluAdd = 5'd0;
    localparam logic [aluOpWidth-1:0] aluSub = 5'd1;
    localparam logic [aluOpWidth-1:0] aluAnd = 5'd2;
    localparam logic [aluOpWidth-1:0] aluOr  = 5'd3;
    localparam logic [aluOpWidth-1:0] aluXor = 5'd4;
    localparam logic [aluOpWidth-1:0] aluNor = 5'd5;
    localparam logic [aluOpWidth-1:0] aluSlt = 5'd6;
    localparam logic [aluOpWidth-1:0] aluSll = 5'd7;
    localparam logic [aluOpWidth-1:0] aluSrl = 5'd8;
    localparam logic [aluOpWidth-1:0] aluLui = 5'd9;

    ////////////////////
    // Opcodes
    localparam logic [opcodeWidth-1:0] opRType = 6'h00;
    localparam logic [opcodeWidth-1:0] opBeq   = 6'h04;
    localparam logic [opcodeWidth-1:0] opBne   = 6'h05;
    localparam logic [opcodeWidth-1:0] opAddi  = 6'h08;
    localparam logic [opcodeWidth-1:0] opSlti  = 6'h0a;
    localparam logic [opcodeWidth-1:0] opAndi  = 6'h0c;
    localparam logic [opcodeWidth-1:0] opOri   = 6'h0d;
    localparam logic [opcodeWidth-1:0] opLui   = 6'h0f;
    localparam logic [opcodeWidth-1:0] opLb    = 6'h20;
    localparam logic [opcodeWidth-1:0] opLw    = 6'h23;
    localparam logic [opcodeWidth-1:0] opSb    = 6'h28;
    localparam logic [opcodeWidth-1:0] opSw    = 6'h2b;

    // Function codes of R-type
    localparam logic [functWidth-1:0] fnSll = 6'h00;
    localparam logic [functWidth-1:0] fnSrl = 6'h02;
    localparam logic [functWidth-1:0] fnAdd = 6'h20;
    localparam logic [functWidth-1:0] fnSub = 6'h22;
    localparam logic [functWidth-1:0] fnAnd = 6'h24;
    localparam logic [functWidth-1:0] fnOr  = 6'h25;
    localparam logic [functWidth-1:0] fnXor = 6'h26;
    localparam logic [functWidth-1:0] fnNor = 6'h27;
    localparam logic [functWidth-1:0] fnSlt = 6'h2a;

    ////////////////////
    // Writeback source, access size and destination selection
    localparam logic [1:0] memToRegAlu = 2'b01;
    localparam logic [1:0] memToRegMem = 2'b10;
    localparam logic [1:0] byteSelByte = 2'b01;
    localparam logic [1:0] byteSelWord = 2'b11;
    localparam logic [1:0] regDstRt    = 2'b01;
    localparam logic [1:0] regDstRd    = 2'b10;

    // One instruction word seen as R-type or I-type
    typedef union packed {
        struct packed {
            logic [opcodeWidth-1:0]  opcode;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rt;
            logic [regAddrWidth-1:0] rd;
            logic [regAddrWidth-1:0] shamt;
            logic [functWidth-1:0]   funct;
        } rType;
        struct packed {
            logic [opcodeWidth-1:0]  opcode;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rt;
            logic [immWidth-1:0]     imm;
        } iType;
    } instrWord;

endpackage

// File: registerFile.sv
`timescale 1ns/1ns

module registerFile (
    input  logic                              Clock,
    input  logic                              arstN,
    input  logic                              writeEnable,
    input  logic [mipsPkg::regAddrWidth-1:0]  readAddr1,
    input  logic [mipsPkg::regAddrWidth-1:0]  readAddr2,
    input  logic [mipsPkg::regAddrWidth-1:0]  writeAddr,
    input  logic [mipsPkg::dataWidth-1:0]     writeData,
    output logic [mipsPkg::dataWidth-1:0]     readData1,
    output logic [mipsPkg::dataWidth-1:0]     readData2
);
    import mipsPkg::*;

    logic [dataWidth-1:0] regs [regCount];
    logic                 writeLive;

    // Register 0 never takes a write
    assign writeLive = writeEnable && (writeAddr != '0);

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeLive) begin
            regs[writeAddr] <= writeData;
        end
    end

    ////////////////////
    // Reads, with the pending write returned first
    assign readData1 = (writeLive && writeAddr == readAddr1) ? writeData : regs[readAddr1];
    assign readData2 = (writeLive && writeAddr == readAddr2) ? writeData : regs[readAddr2];

    assert property (@(posedge Clock) disable iff (!arstN)
        (readAddr1 == '0) |-> (readData1 == '0))
        else $error("register 0 read nonzero on port 1");
    assert property (@(posedge Clock) disable iff (!arstN)
        (readAddr2 == '0) |-> (readData2 == '0))
        else $error("register 0 read nonzero on port 2");

endmodule
